// ==== filelist.f ====
+incdir+.
disc_pkg.sv
disc_config_regs.sv
hysteresis_trigger.sv
sample_delay_line.sv
channel_discriminator.sv
sample_discriminator.sv
sample_discriminator_assertions.sv
tb_sample_discriminator.sv

// ==== Bender.yml ====
package:
  name: sample_discriminator

sources:
  - include_dirs:
      - .
    files:
      - disc_pkg.sv
      - disc_config_regs.sv
      - hysteresis_trigger.sv
      - sample_delay_line.sv
      - channel_discriminator.sv
      - sample_discriminator.sv
  - target: test
    include_dirs:
      - .
    files:
      - sample_discriminator_assertions.sv
      - tb_sample_discriminator.sv

// ==== tb_sample_discriminator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "disc_params.svh"

module tb_sample_discriminator;

  localparam int CH          = `DISC_CHANNELS;
  localparam int NUM_TESTS   = 4;
  localparam int NUM_SAMPLES = 48;
  localparam int MAX_CYCLES  = NUM_TESTS * (NUM_SAMPLES * 3 + 200);

  // one row of the test table, 'hff marks an unused trigger pulse
  typedef struct packed {
    disc_pkg::chan_cfg_t [CH-1:0] cfg;
    logic [CH-1:0][1:0][7:0]      ext_pos;
    logic [7:0]                   n_samples;
  } test_row_t;

  logic                              adc_clk = 1'b0;
  logic                              rst_n_i;
  logic                              reset_state_i;
  disc_pkg::wb_req_t                 wb_req;
  disc_pkg::wb_rsp_t                 wb_rsp;
  disc_pkg::sample_beat_t [CH-1:0]   data_in;
  logic [CH-1:0]                     ext_trig;
  disc_pkg::sample_beat_t [CH-1:0]   data_out;
  disc_pkg::tstamp_beat_t [CH-1:0]   ts_out;

  test_row_t                    tests [NUM_TESTS];
  disc_pkg::chan_cfg_t [CH-1:0] eff_cfg;
  disc_pkg::sample_t            samples [CH][NUM_SAMPLES];
  logic                         trig_src [2*CH][NUM_SAMPLES];
  disc_pkg::sample_t            exp_samples [CH][$];
  disc_pkg::tstamp_t            exp_tstamps [CH][$];
  int                           seed = 20880;
  int                           cycles = 0;

  sample_discriminator i_dut (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .reset_state_i (reset_state_i),
    .wb_req_i      (wb_req),
    .wb_rsp_o      (wb_rsp),
    .data_i        (data_in),
    .ext_trig_i    (ext_trig),
    .data_o        (data_out),
    .tstamp_o      (ts_out)
  );

  always #50 adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_sample(input int ch, input disc_pkg::sample_t got,
                              input disc_pkg::sample_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: channel %0d sample %0d, expected %0d", $time, ch, got, exp);
      abort_run();
    end
  endtask

  task automatic check_tstamp(input int ch, input disc_pkg::tstamp_t got,
                              input disc_pkg::tstamp_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: channel %0d timestamp %0d, expected %0d", $time, ch, got, exp);
      abort_run();
    end
  endtask

  task automatic check_reg(input int word, input disc_pkg::wb_dat_t got,
                           input disc_pkg::wb_dat_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: register word %0d read %h, expected %h", $time, word, got, exp);
      abort_run();
    end
  endtask

  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end else if (i_dut.u_assertions.fail_count != 0) begin
      $display("a bound assertion failed at %0t", $time);
      abort_run();
    end
  end

  // outputs change on the rising edge, so look at them on the falling one
  always @(negedge adc_clk) begin
    if (rst_n_i) begin
      for (int c = 0; c < CH; c++) begin
        if (data_out[c].valid) begin
          if (exp_samples[c].size() == 0) begin
            $display("channel %0d put out a sample that was not expected at %0t", c, $time);
            abort_run();
          end else begin
            check_sample(c, data_out[c].data, exp_samples[c].pop_front());
          end
        end
        if (ts_out[c].valid) begin
          if (exp_tstamps[c].size() == 0) begin
            $display("channel %0d put out a timestamp that was not expected at %0t", c, $time);
            abort_run();
          end else begin
            check_tstamp(c, ts_out[c].value, exp_tstamps[c].pop_front());
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test table and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic set_channel_row(input int t, input int c, input int low, input int high,
                                 input int start, input int stop, input int src,
                                 input int dis);
    tests[t].cfg[c].low      = disc_pkg::sample_t'(low);
    tests[t].cfg[c].high     = disc_pkg::sample_t'(high);
    tests[t].cfg[c].start    = disc_pkg::delay_t'(start);
    tests[t].cfg[c].stop     = disc_pkg::delay_t'(stop);
    tests[t].cfg[c].src      = disc_pkg::src_sel_t'(src);
    tests[t].cfg[c].disabled = dis[0];
  endtask

  task automatic set_trigger_pulses(input int t, input int p00, input int p01,
                                    input int p10, input int p11);
    tests[t].ext_pos[0][0] = 8'(p00);
    tests[t].ext_pos[0][1] = 8'(p01);
    tests[t].ext_pos[1][0] = 8'(p10);
    tests[t].ext_pos[1][1] = 8'(p11);
    tests[t].n_samples     = 8'(NUM_SAMPLES);
  endtask

  task automatic load_table();
    // self triggered hysteresis windows
    set_channel_row(0, 0, -600, 600, 2, 3, 0, 0);
    set_channel_row(0, 1, -200, 800, 0, 0, 1, 0);
    set_trigger_pulses(0, 255, 255, 255, 255);
    // each channel follows the other comparator
    set_channel_row(1, 0, -500, 700, 5, 1, 1, 0);
    set_channel_row(1, 1, -800, 300, 3, 7, 0, 0);
    set_trigger_pulses(1, 255, 255, 255, 255);
    // digital trigger inputs
    set_channel_row(2, 0, 0, 900, 4, 6, 2, 0);
    set_channel_row(2, 1, -100, 100, 1, 2, 3, 0);
    set_trigger_pulses(2, 10, 30, 5, 40);
    // disabled channel, delays above the limit get clamped
    set_channel_row(3, 0, -600, 600, 20, 31, 0, 1);
    set_channel_row(3, 1, -900, 950, 15, 0, 2, 0);
    set_trigger_pulses(3, 20, 255, 255, 255);
  endtask

  task automatic wb_access(input logic we, input int word, input disc_pkg::wb_dat_t wdata,
                           output disc_pkg::wb_dat_t rdata);
    @(negedge adc_clk);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = disc_pkg::wb_adr_t'(4 * word);
    wb_req.dat_w = wdata;
    @(negedge adc_clk);
    while (!wb_rsp.ack) @(negedge adc_clk);
    rdata  = wb_rsp.dat_r;
    wb_req = '0;
  endtask

  function automatic disc_pkg::delay_t limit_delay(input disc_pkg::delay_t raw);
    return (raw > `DISC_MAX_DELAY - 1) ? disc_pkg::delay_t'(`DISC_MAX_DELAY - 1) : raw;
  endfunction

  task automatic write_config(input int t);
    disc_pkg::wb_dat_t wdata;
    disc_pkg::wb_dat_t rd;
    // upper bits of the disable word are not backed by storage
    wdata = 32'ha5a5_0000;
    for (int c = 0; c < CH; c++) wdata[c] = tests[t].cfg[c].disabled;
    wb_access(1'b1, 0, wdata, rd);
    for (int c = 0; c < CH; c++) begin
      eff_cfg[c]       = tests[t].cfg[c];
      eff_cfg[c].start = limit_delay(tests[t].cfg[c].start);
      eff_cfg[c].stop  = limit_delay(tests[t].cfg[c].stop);
      wb_access(1'b1, 1 + 3*c, {tests[t].cfg[c].high, tests[t].cfg[c].low}, rd);
      wdata        = '0;
      wdata[4:0]   = tests[t].cfg[c].start;
      wdata[12:8]  = tests[t].cfg[c].stop;
      wb_access(1'b1, 2 + 3*c, wdata, rd);
      wdata        = '0;
      wdata[1:0]   = tests[t].cfg[c].src;
      wb_access(1'b1, 3 + 3*c, wdata, rd);
    end
    wb_access(1'b1, 7, '1, rd);
    wb_access(1'b1, 63, '1, rd);
  endtask

  task automatic read_and_check(input int word, input disc_pkg::wb_dat_t exp);
    disc_pkg::wb_dat_t rd;
    wb_access(1'b0, word, '0, rd);
    check_reg(word, rd, exp);
  endtask

  task automatic read_config();
    disc_pkg::wb_dat_t exp;
    exp = '0;
    for (int c = 0; c < CH; c++) exp[c] = eff_cfg[c].disabled;
    read_and_check(0, exp);
    for (int c = 0; c < CH; c++) begin
      read_and_check(1 + 3*c, {eff_cfg[c].high, eff_cfg[c].low});
      exp        = '0;
      exp[4:0]   = eff_cfg[c].start;
      exp[12:8]  = eff_cfg[c].stop;
      read_and_check(2 + 3*c, exp);
      exp        = '0;
      exp[1:0]   = eff_cfg[c].src;
      read_and_check(3 + 3*c, exp);
    end
    read_and_check(7, '0);
    read_and_check(63, '0);
  endtask

  // reference model of the comparators and the keep window
  task automatic build_expected(input int t);
    int   n;
    int   s;
    int   e;
    int   src;
    logic armed;
    logic keep;
    logic prev;
    n = tests[t].n_samples;
    for (int c = 0; c < CH; c++) begin
      exp_samples[c].delete();
      exp_tstamps[c].delete();
      armed = 1'b0;
      for (int j = 0; j < n; j++) begin
        samples[c][j] = disc_pkg::sample_t'($random(seed) % 1000);
        if (!armed && samples[c][j] > eff_cfg[c].high) armed = 1'b1;
        else if (armed && samples[c][j] < eff_cfg[c].low) armed = 1'b0;
        trig_src[c][j] = armed;
      end
    end
    for (int k = 0; k < CH; k++) begin
      for (int j = 0; j < n; j++) begin
        trig_src[CH+k][j] = (j == int'(tests[t].ext_pos[k][0])) ||
                            (j == int'(tests[t].ext_pos[k][1]));
      end
    end
    for (int c = 0; c < CH; c++) begin
      s    = eff_cfg[c].start;
      e    = eff_cfg[c].stop;
      src  = eff_cfg[c].src;
      prev = 1'b0;
      // sample m is only put out once sample m plus start has arrived
      for (int m = 0; m + s < n; m++) begin
        keep = eff_cfg[c].disabled;
        for (int j = m - e; j <= m + s; j++) begin
          if (j >= 0 && trig_src[src][j]) keep = 1'b1;
        end
        if (keep) exp_samples[c].push_back(samples[c][m]);
        if (keep && !prev) exp_tstamps[c].push_back(disc_pkg::tstamp_t'(m));
        prev = keep;
      end
    end
  endtask

  task automatic stream_samples(input int t);
    int j;
    int n;
    n = tests[t].n_samples;
    j = 0;
    while (j < n) begin
      @(negedge adc_clk);
      if (($random(seed) & 3) == 0) begin
        data_in  = '0;
        ext_trig = '0;
      end else begin
        for (int c = 0; c < CH; c++) begin
          data_in[c].valid = 1'b1;
          data_in[c].data  = samples[c][j];
          ext_trig[c]      = trig_src[CH+c][j];
        end
        j++;
      end
    end
    @(negedge adc_clk);
    data_in  = '0;
    ext_trig = '0;
  endtask

  task automatic drain_and_check();
    repeat (`DISC_MAX_DELAY + 4) @(negedge adc_clk);
    for (int c = 0; c < CH; c++) begin
      if (exp_samples[c].size() != 0 || exp_tstamps[c].size() != 0) begin
        $display("channel %0d never put out %0d samples and %0d timestamps", c,
                 exp_samples[c].size(), exp_tstamps[c].size());
        abort_run();
      end
    end
  endtask

  initial begin
    rst_n_i       = 1'b1;
    reset_state_i = 1'b0;
    wb_req        = '0;
    data_in       = '0;
    ext_trig      = '0;
    load_table();
    // a clean falling edge so the asynchronous reset fires
    #10;
    rst_n_i = 1'b0;
    repeat (4) @(negedge adc_clk);
    rst_n_i = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      write_config(t);
      read_config();
      build_expected(t);
      @(negedge adc_clk);
      reset_state_i = 1'b1;
      @(negedge adc_clk);
      reset_state_i = 1'b0;
      stream_samples(t);
      drain_and_check();
    end
    if (i_dut.u_assertions.fail_count != 0) begin
      $display("%0d assertion failures were seen", i_dut.u_assertions.fail_count);
      abort_run();
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sample_discriminator_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "disc_params.svh"

module sample_discriminator_assertions (
  input logic                                        adc_clk,
  input logic                                        rst_n_i,
  input logic                                        reset_state_i,
  input disc_pkg::wb_req_t                           wb_req_i,
  input disc_pkg::wb_rsp_t                           wb_rsp_o,
  input disc_pkg::sample_beat_t [`DISC_CHANNELS-1:0] data_o,
  input disc_pkg::tstamp_beat_t [`DISC_CHANNELS-1:0] tstamp_o
);

  logic [`DISC_CHANNELS-1:0] data_valid;
  logic [`DISC_CHANNELS-1:0] ts_valid;
  int                        fail_count = 0;

  always_comb begin
    for (int c = 0; c < `DISC_CHANNELS; c++) begin
      data_valid[c] = data_o[c].valid;
      ts_valid[c]   = tstamp_o[c].valid;
    end
  end

  // single cycle ack, only while a request is up
  ack_single_cycle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    wb_rsp_o.ack |=> !wb_rsp_o.ack)
    else begin
      $error("wishbone ack held for more than one cycle");
      fail_count++;
    end

  ack_with_request: assert property (@(posedge adc_clk)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else begin
      $error("wishbone ack without cyc and stb");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge adc_clk)
    !rst_n_i |-> (data_valid == '0 && ts_valid == '0 && !wb_rsp_o.ack))
    else begin
      $error("output valid while in reset");
      fail_count++;
    end

  quiet_after_state_reset: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    reset_state_i |=> (data_valid == '0 && ts_valid == '0))
    else begin
      $error("output valid after state reset");
      fail_count++;
    end

  tstamp_needs_sample: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (ts_valid & ~data_valid) == '0)
    else begin
      $error("timestamp valid without its sample");
      fail_count++;
    end

endmodule

bind sample_discriminator sample_discriminator_assertions u_assertions (
  .adc_clk       (adc_clk),
  .rst_n_i       (rst_n_i),
  .reset_state_i (reset_state_i),
  .wb_req_i      (wb_req_i),
  .wb_rsp_o      (wb_rsp_o),
  .data_o        (data_o),
  .tstamp_o      (tstamp_o)
);

`default_nettype wire

// ==== sample_discriminator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "disc_params.svh"

module sample_discriminator (
  input  logic                                        adc_clk,
  input  logic                                        rst_n_i,
  input  logic                                        reset_state_i,
  input  disc_pkg::wb_req_t                           wb_req_i,
  output disc_pkg::wb_rsp_t                           wb_rsp_o,
  input  disc_pkg::sample_beat_t [`DISC_CHANNELS-1:0] data_i,
  input  logic [`DISC_CHANNELS-1:0]                   ext_trig_i,
  output disc_pkg::sample_beat_t [`DISC_CHANNELS-1:0] data_o,
  output disc_pkg::tstamp_beat_t [`DISC_CHANNELS-1:0] tstamp_o
);

  localparam int CH = `DISC_CHANNELS;

  disc_pkg::chan_cfg_t [CH-1:0] cfg;
  logic [CH-1:0]                armed;

  disc_config_regs u_regs (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .cfg_o    (cfg)
  );

  //////////////////////////////////////////////////////////////////////
  // per-channel comparators and discriminators
  //////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < CH; c++) begin : g_chan

    hysteresis_trigger u_hyst (
      .adc_clk       (adc_clk),
      .rst_n_i       (rst_n_i),
      .reset_state_i (reset_state_i),
      .beat_i        (data_i[c]),
      .low_i         (cfg[c].low),
      .high_i        (cfg[c].high),
      .armed_o       (armed[c])
    );

    // every channel sees all comparators and all digital inputs
    channel_discriminator u_disc (
      .adc_clk       (adc_clk),
      .rst_n_i       (rst_n_i),
      .reset_state_i (reset_state_i),
      .cfg_i         (cfg[c]),
      .beat_i        (data_i[c]),
      .trig_vec_i    ({ext_trig_i, armed}),
      .beat_o        (data_o[c]),
      .tstamp_o      (tstamp_o[c])
    );

  end

endmodule

`default_nettype wire

// ==== channel_discriminator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "disc_params.svh"

module channel_discriminator (
  input  logic                          adc_clk,
  input  logic                          rst_n_i,
  input  logic                          reset_state_i,
  input  disc_pkg::chan_cfg_t           cfg_i,
  input  disc_pkg::sample_beat_t        beat_i,
  input  logic [2*`DISC_CHANNELS-1:0]   trig_vec_i,
  output disc_pkg::sample_beat_t        beat_o,
  output disc_pkg::tstamp_beat_t        tstamp_o
);

  localparam int CH     = `DISC_CHANNELS;
  localparam int HOLD_W = $bits(disc_pkg::delay_t) + 1;

  disc_pkg::sample_beat_t beat_q;
  logic [CH-1:0]          ext_q;
  logic [2*CH-1:0]        src_vec;
  logic                   trig_sel;
  disc_pkg::sample_beat_t dly_beat;
  logic                   dly_trig;
  logic                   filled;
  logic [HOLD_W-1:0]      hold_q;
  logic                   keep;
  logic                   out_beat;
  logic                   prev_kept_q;
  disc_pkg::tstamp_t      idx_q;

  //////////////////////////////////////////////////////////////////////
  // stage 1: line up the sample with its trigger
  //////////////////////////////////////////////////////////////////////

  // comparator bits already lag by one cycle, digital bits are caught here
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_q <= '0;
      ext_q  <= '0;
    end else if (reset_state_i) begin
      beat_q <= '0;
      ext_q  <= '0;
    end else begin
      beat_q <= beat_i;
      if (beat_i.valid) begin
        ext_q <= trig_vec_i[2*CH-1:CH];
      end
    end
  end

  assign src_vec  = {ext_q, trig_vec_i[CH-1:0]};
  assign trig_sel = src_vec[cfg_i.src];

  sample_delay_line #(
    .DEPTH (`DISC_MAX_DELAY)
  ) u_delay (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .reset_state_i (reset_state_i),
    .beat_i        (beat_q),
    .trig_i        (trig_sel),
    .delay_i       (cfg_i.start),
    .beat_o        (dly_beat),
    .trig_o        (dly_trig),
    .filled_o      (filled)
  );

  //////////////////////////////////////////////////////////////////////
  // stage 2: keep window and output
  //////////////////////////////////////////////////////////////////////

  // a trigger now opens the window start beats back and stop beats ahead
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_q <= '0;
    end else if (reset_state_i) begin
      hold_q <= '0;
    end else if (dly_beat.valid) begin
      if (trig_sel) begin
        hold_q <= HOLD_W'(cfg_i.start) + HOLD_W'(cfg_i.stop);
      end else if (hold_q != '0) begin
        hold_q <= hold_q - 1'b1;
      end
    end
  end

  // samples from before the line refilled have no index and are dropped
  assign out_beat = dly_beat.valid & filled;
  assign keep     = cfg_i.disabled | dly_trig | trig_sel | (hold_q != '0);

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_o      <= '0;
      tstamp_o    <= '0;
      idx_q       <= '0;
      prev_kept_q <= 1'b0;
    end else if (reset_state_i) begin
      beat_o      <= '0;
      tstamp_o    <= '0;
      idx_q       <= '0;
      prev_kept_q <= 1'b0;
    end else begin
      beat_o.valid   <= out_beat & keep;
      beat_o.data    <= dly_beat.data;
      // new segment when the previous sample was dropped
      tstamp_o.valid <= out_beat & keep & ~prev_kept_q;
      tstamp_o.value <= idx_q;
      if (out_beat) begin
        idx_q       <= idx_q + 1'b1;
        prev_kept_q <= keep;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sample_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line #(
  parameter int DEPTH = 16
) (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  logic                   reset_state_i,
  input  disc_pkg::sample_beat_t beat_i,
  input  logic                   trig_i,
  input  disc_pkg::delay_t       delay_i,
  output disc_pkg::sample_beat_t beat_o,
  output logic                   trig_o,
  output logic                   filled_o
);

  localparam int PW = $clog2(DEPTH);

  disc_pkg::sample_t data_mem [DEPTH];
  logic [DEPTH-1:0]  trig_mem;
  logic [PW-1:0]     wr_ptr_q;
  logic [PW-1:0]     rd_ptr;
  logic [PW:0]       fill_q;
  logic              bypass;

  // wr_ptr points at the next free slot, so minus d is d beats back
  assign rd_ptr = wr_ptr_q - PW'(delay_i);
  assign bypass = (delay_i == '0);

  always_ff @(posedge adc_clk) begin
    if (beat_i.valid) begin
      data_mem[wr_ptr_q] <= beat_i.data;
      trig_mem[wr_ptr_q] <= trig_i;
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      fill_q   <= '0;
    end else if (reset_state_i) begin
      wr_ptr_q <= '0;
      fill_q   <= '0;
    end else if (beat_i.valid) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
      // saturate once the whole line holds fresh data
      if (fill_q != (PW+1)'(DEPTH)) begin
        fill_q <= fill_q + 1'b1;
      end
    end
  end

  // read happens on the same beat as the write
  always_comb begin
    beat_o.valid = beat_i.valid;
    beat_o.data  = bypass ? beat_i.data : data_mem[rd_ptr];
    trig_o       = bypass ? trig_i : trig_mem[rd_ptr];
  end

  assign filled_o = (fill_q >= (PW+1)'(delay_i));

endmodule

`default_nettype wire

// ==== hysteresis_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module hysteresis_trigger (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  logic                   reset_state_i,
  input  disc_pkg::sample_beat_t beat_i,
  input  disc_pkg::sample_t      low_i,
  input  disc_pkg::sample_t      high_i,
  output logic                   armed_o
);

  disc_pkg::arm_state_t state_q;
  disc_pkg::arm_state_t state_d;
  logic                 above;
  logic                 below;

  // both operands are signed samples
  assign above = beat_i.data > high_i;
  assign below = beat_i.data < low_i;

  // between the two levels the state is held
  always_comb begin
    state_d = state_q;
    if (beat_i.valid) begin
      case (state_q)
        disc_pkg::ST_DISARMED: begin
          if (above) state_d = disc_pkg::ST_ARMED;
        end
        disc_pkg::ST_ARMED: begin
          if (below) state_d = disc_pkg::ST_DISARMED;
        end
        default: state_d = disc_pkg::ST_DISARMED;
      endcase
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= disc_pkg::ST_DISARMED;
    end else if (reset_state_i) begin
      state_q <= disc_pkg::ST_DISARMED;
    end else begin
      state_q <= state_d;
    end
  end

  // state after the last valid sample, one cycle behind that sample
  assign armed_o = (state_q == disc_pkg::ST_ARMED);

endmodule

`default_nettype wire

// ==== disc_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "disc_params.svh"

module disc_config_regs (
  input  logic                                     adc_clk,
  input  logic                                     rst_n_i,
  input  disc_pkg::wb_req_t                        wb_req_i,
  output disc_pkg::wb_rsp_t                        wb_rsp_o,
  output disc_pkg::chan_cfg_t [`DISC_CHANNELS-1:0] cfg_o
);

  localparam int CH     = `DISC_CHANNELS;
  localparam int WORD_W = `DISC_WB_ADDR_WIDTH - 2;

  disc_pkg::chan_cfg_t [CH-1:0] cfg_q;
  logic [WORD_W-1:0]            word;
  logic                         req;
  logic                         ack_q;
  disc_pkg::wb_dat_t            rd_data;
  disc_pkg::wb_dat_t            dat_q;

  // largest delay the line can hold is depth minus one
  function automatic disc_pkg::delay_t clamp_delay(input disc_pkg::delay_t raw);
    if (raw > disc_pkg::delay_t'(`DISC_MAX_DELAY - 1)) begin
      return disc_pkg::delay_t'(`DISC_MAX_DELAY - 1);
    end
    return raw;
  endfunction

  assign word = wb_req_i.adr[`DISC_WB_ADDR_WIDTH-1:2];
  // request not yet answered, so ack stays a single cycle
  assign req  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  //////////////////////////////////////////////////////////////////////
  // handshake and read data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req) begin
      dat_q <= rd_data;
    end
  end

  always_comb begin
    wb_rsp_o.ack   = ack_q & wb_req_i.cyc & wb_req_i.stb;
    wb_rsp_o.dat_r = dat_q;
  end

  // unmapped words fall through as zero
  always_comb begin
    rd_data = '0;
    if (word == '0) begin
      for (int c = 0; c < CH; c++) begin
        rd_data[c] = cfg_q[c].disabled;
      end
    end
    for (int c = 0; c < CH; c++) begin
      if (word == WORD_W'(1 + 3*c)) begin
        rd_data = {cfg_q[c].high, cfg_q[c].low};
      end
      if (word == WORD_W'(2 + 3*c)) begin
        rd_data[4:0]  = cfg_q[c].start;
        rd_data[12:8] = cfg_q[c].stop;
      end
      if (word == WORD_W'(3 + 3*c)) begin
        rd_data[1:0] = cfg_q[c].src;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (req && wb_req_i.we) begin
      for (int c = 0; c < CH; c++) begin
        if (word == '0) begin
          cfg_q[c].disabled <= wb_req_i.dat_w[c];
        end
        if (word == WORD_W'(1 + 3*c)) begin
          cfg_q[c].low  <= disc_pkg::sample_t'(wb_req_i.dat_w[15:0]);
          cfg_q[c].high <= disc_pkg::sample_t'(wb_req_i.dat_w[31:16]);
        end
        if (word == WORD_W'(2 + 3*c)) begin
          cfg_q[c].start <= clamp_delay(wb_req_i.dat_w[4:0]);
          cfg_q[c].stop  <= clamp_delay(wb_req_i.dat_w[12:8]);
        end
        if (word == WORD_W'(3 + 3*c)) begin
          cfg_q[c].src <= wb_req_i.dat_w[1:0];
        end
      end
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// ==== disc_pkg.sv ====
`default_nettype none
`include "disc_params.svh"

package disc_pkg;

  // widths with a meaning
  typedef logic signed [`DISC_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [$clog2(`DISC_MAX_DELAY):0] delay_t;
  typedef logic [`DISC_TSTAMP_WIDTH-1:0] tstamp_t;
  // below channel count selects a comparator, above it a digital input
  typedef logic [$clog2(2*`DISC_CHANNELS)-1:0] src_sel_t;
  typedef logic [`DISC_WB_ADDR_WIDTH-1:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // hysteresis comparator state
  typedef enum logic {
    ST_DISARMED,
    ST_ARMED
  } arm_state_t;

  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_beat_t;

  typedef struct packed {
    logic    valid;
    tstamp_t value;
  } tstamp_beat_t;

  typedef struct packed {
    sample_t  low;
    sample_t  high;
    delay_t   start;
    delay_t   stop;
    src_sel_t src;
    logic     disabled;
  } chan_cfg_t;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat_w;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== disc_params.svh ====
`ifndef DISC_PARAMS_SVH
`define DISC_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// discriminator sizing
//////////////////////////////////////////////////////////////////////

// number of ADC channels, also the number of digital trigger inputs
`define DISC_CHANNELS 2

// signed ADC sample width
`define DISC_SAMPLE_WIDTH 16

// delay line depth, largest usable start or stop delay is one less
`define DISC_MAX_DELAY 16

// sample index width
`define DISC_TSTAMP_WIDTH 32

// byte address width of the register slave
`define DISC_WB_ADDR_WIDTH 8

`endif
